//--- exe_pipe.f
+incdir+common
common/exe_pipe_pkg.sv
common/fwd_if.sv
ex1/ex1_forward.sv
ex1/ex1_stage.sv
verilog/ex2_stage.sv
verilog/wb_stage.sv
verilog/exe_pipe_top.sv
verif/exe_pipe_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exe_pipe_tb -f exe_pipe.f

out=$(./obj_dir/Vexe_pipe_tb)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- verif/exe_pipe_tb.sv
`timescale 1ns/10ps
`include "exe_pipe_settings.svh"
`default_nettype none

module exe_pipe_tb;

    localparam int READY_LIMIT  = 16;
    localparam int DRAIN_LIMIT  = 64;
    localparam int RANDOM_COUNT = 300;
    localparam int NREG         = 1 << `EXE_NREG_BITS;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     in_valid_i;
    exe_pipe_pkg::alu_op_e    in_op_i;
    exe_pipe_pkg::reg_t       in_rd_i;
    exe_pipe_pkg::reg_t       in_rj_i;
    exe_pipe_pkg::reg_t       in_rk_i;
    logic [`EXE_IMM_BITS-1:0] in_imm_i;
    logic                     ready_o;
    logic                     wb_valid_o;
    exe_pipe_pkg::reg_t       wb_rd_o;
    exe_pipe_pkg::word_t      wb_data_o;

    // architectural model, updated in program order at acceptance
    exe_pipe_pkg::word_t   model_rf [NREG];
    exe_pipe_pkg::reg_t    exp_rd_q [$];
    exe_pipe_pkg::word_t   exp_data_q [$];
    int                    exp_cyc_q [$];
    logic                  ex1_busy;
    exe_pipe_pkg::alu_op_e ex1_op;
    exe_pipe_pkg::reg_t    ex1_rd;
    logic                  exp_ready;
    int                    cycle_cnt;
    logic [31:0]           rng_state;

    int value_errors;
    int order_errors;
    int timeout_errors;
    int accepted;
    int stalls;

    exe_pipe_top dut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_rd_i    (in_rd_i),
        .in_rj_i    (in_rj_i),
        .in_rk_i    (in_rk_i),
        .in_imm_i   (in_imm_i),
        .ready_o    (ready_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic exe_pipe_pkg::word_t model_result(
        input exe_pipe_pkg::alu_op_e    op,
        input exe_pipe_pkg::word_t      a,
        input exe_pipe_pkg::word_t      b,
        input logic [`EXE_IMM_BITS-1:0] imm
    );
        exe_pipe_pkg::word_t res;
        res = '0;
        case (op)
            exe_pipe_pkg::op_add: res = a + b;
            exe_pipe_pkg::op_sub: res = a - b;
            exe_pipe_pkg::op_and: res = a & b;
            exe_pipe_pkg::op_or:  res = a | b;
            exe_pipe_pkg::op_xor: res = a ^ b;
            exe_pipe_pkg::op_slt: res[0] = $signed(a) < $signed(b);
            exe_pipe_pkg::op_li:  res = int'($signed(imm));
            exe_pipe_pkg::op_mul: res = a * b;
            default:              res = '0;
        endcase
        return res;
    endfunction

    // drive one instruction and hold it until the DUT takes it
    task automatic issue(
        input exe_pipe_pkg::alu_op_e    op,
        input int                       rd,
        input int                       rj,
        input int                       rk,
        input logic [`EXE_IMM_BITS-1:0] imm
    );
        int waited;
        waited = 0;
        in_valid_i <= 1'b1;
        in_op_i    <= op;
        in_rd_i    <= exe_pipe_pkg::reg_t'(rd);
        in_rj_i    <= exe_pipe_pkg::reg_t'(rj);
        in_rk_i    <= exe_pipe_pkg::reg_t'(rk);
        in_imm_i   <= imm;
        @(negedge clk_i);
        while (ready_o !== 1'b1 && waited < READY_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (ready_o !== 1'b1) begin
            $display("timeout: ready_o stayed low for %0d cycles", READY_LIMIT);
            timeout_errors++;
        end
        @(posedge clk_i);
    endtask

    task automatic idle(input int cycles);
        in_valid_i <= 1'b0;
        repeat (cycles) @(posedge clk_i);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        in_valid_i <= 1'b0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("timeout: %0d instructions never retired", exp_rd_q.size());
            timeout_errors++;
        end
    endtask

    task automatic random_run(input int count);
        logic [31:0]           r;
        logic [31:0]           s;
        exe_pipe_pkg::alu_op_e op;
        for (int i = 0; i < count; i++) begin
            r  = next_rand();
            s  = next_rand();
            op = exe_pipe_pkg::alu_op_e'(r[31:29]);
            // narrow register window keeps hazards frequent
            issue(op, int'(r[28:26]), int'(r[25:23]), int'(r[22:20]), s[31:20]);
            if (r[19:17] == 3'd0) begin
                idle(1);
            end
        end
    endtask

    // checks at the falling edge, where everything is settled
    always @(negedge clk_i) begin : monitor
        logic                stall;
        exe_pipe_pkg::word_t result;
        if (rst_n_i) begin
            cycle_cnt++;
            assert (ready_o === exp_ready) else begin
                $display("FAIL ready_o expected %h actual %h", exp_ready, ready_o);
                value_errors++;
            end
            if (wb_valid_o === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    $display("retirement at cycle %0d with nothing outstanding", cycle_cnt);
                    order_errors++;
                end else begin
                    assert (wb_rd_o === exp_rd_q[0]) else begin
                        $display("FAIL wb_rd_o expected %h actual %h", exp_rd_q[0], wb_rd_o);
                        value_errors++;
                    end
                    assert (wb_data_o === exp_data_q[0]) else begin
                        $display("FAIL wb_data_o expected %h actual %h",
                                 exp_data_q[0], wb_data_o);
                        value_errors++;
                    end
                    assert (cycle_cnt == exp_cyc_q[0]) else begin
                        $display("retired at cycle %0d instead of cycle %0d",
                                 cycle_cnt, exp_cyc_q[0]);
                        order_errors++;
                    end
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end else begin
                // nothing retires, so the oldest one is due later
                assert (exp_cyc_q.size() == 0 || exp_cyc_q[0] > cycle_cnt) else begin
                    $display("FAIL wb_valid_o expected %h actual %h (r%0d due at cycle %0d)",
                             1'b1, wb_valid_o, exp_rd_q[0], exp_cyc_q[0]);
                    value_errors++;
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end
            // the next rising edge accepts what is on the inputs now
            if (ready_o === 1'b1) begin
                stall = 1'b0;
                if (in_valid_i) begin
                    stall = ex1_busy && ex1_op == exe_pipe_pkg::op_mul && ex1_rd != '0
                          && (in_rj_i == ex1_rd || in_rk_i == ex1_rd);
                    result = model_result(in_op_i, model_rf[in_rj_i], model_rf[in_rk_i],
                                          in_imm_i);
                    exp_rd_q.push_back(in_rd_i);
                    exp_data_q.push_back(result);
                    exp_cyc_q.push_back(cycle_cnt + 3 + (stall ? 1 : 0));
                    if (in_rd_i != '0) begin
                        model_rf[in_rd_i] = result;
                    end
                    accepted++;
                    if (stall) begin
                        stalls++;
                    end
                end
                exp_ready = ~stall;
                ex1_busy  = in_valid_i;
                ex1_op    = in_op_i;
                ex1_rd    = in_rd_i;
            end else begin
                exp_ready = 1'b1;
            end
        end
    end

    initial begin
        rst_n_i        = 1'b0;
        in_valid_i     = 1'b0;
        in_op_i        = exe_pipe_pkg::op_add;
        in_rd_i        = '0;
        in_rj_i        = '0;
        in_rk_i        = '0;
        in_imm_i       = '0;
        ex1_busy       = 1'b0;
        ex1_op         = exe_pipe_pkg::op_add;
        ex1_rd         = '0;
        exp_ready      = 1'b1;
        cycle_cnt      = 0;
        rng_state      = 32'h239b9299;
        value_errors   = 0;
        order_errors   = 0;
        timeout_errors = 0;
        accepted       = 0;
        stalls         = 0;
        for (int i = 0; i < NREG; i++) begin
            model_rf[i] = '0;
        end

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk_i);

        // li with negative immediates too
        issue(exe_pipe_pkg::op_li, 1, 0, 0, 12'h123);
        issue(exe_pipe_pkg::op_li, 2, 0, 0, 12'h800);
        issue(exe_pipe_pkg::op_li, 3, 0, 0, 12'hfff);
        issue(exe_pipe_pkg::op_li, 4, 0, 0, 12'h7ff);
        issue(exe_pipe_pkg::op_li, 5, 0, 0, 12'h9a5);
        drain();

        // forwarding at distance 1 and 2
        issue(exe_pipe_pkg::op_add, 6, 1, 2, 12'h0);
        issue(exe_pipe_pkg::op_sub, 7, 6, 3, 12'h0);
        issue(exe_pipe_pkg::op_xor, 8, 6, 7, 12'h0);
        issue(exe_pipe_pkg::op_slt, 9, 2, 8, 12'h0);
        issue(exe_pipe_pkg::op_or, 10, 9, 4, 12'h0);
        issue(exe_pipe_pkg::op_and, 11, 10, 5, 12'h0);
        // r12 in both slots where the EX2 copy is younger
        issue(exe_pipe_pkg::op_li, 12, 0, 0, 12'h005);
        issue(exe_pipe_pkg::op_li, 12, 0, 0, 12'h7f0);
        issue(exe_pipe_pkg::op_add, 13, 12, 12, 12'h0);
        drain();

        // mul hazards
        issue(exe_pipe_pkg::op_mul, 14, 2, 3, 12'h0);
        issue(exe_pipe_pkg::op_add, 15, 14, 1, 12'h0);
        issue(exe_pipe_pkg::op_mul, 16, 4, 5, 12'h0);
        issue(exe_pipe_pkg::op_and, 17, 1, 3, 12'h0);
        issue(exe_pipe_pkg::op_sub, 18, 16, 17, 12'h0);
        issue(exe_pipe_pkg::op_mul, 19, 18, 18, 12'h0);
        issue(exe_pipe_pkg::op_mul, 20, 19, 19, 12'h0);
        drain();

        // r0 as destination and as source
        issue(exe_pipe_pkg::op_li, 0, 0, 0, 12'h555);
        issue(exe_pipe_pkg::op_add, 21, 0, 1, 12'h0);
        issue(exe_pipe_pkg::op_mul, 0, 2, 3, 12'h0);
        issue(exe_pipe_pkg::op_or, 22, 0, 0, 12'h0);
        drain();

        random_run(RANDOM_COUNT);
        drain();
        idle(4);

        $display("errors: value %0d, order %0d, timeout %0d (%0d accepted, %0d stalls)",
                 value_errors, order_errors, timeout_errors, accepted, stalls);
        if (value_errors + order_errors + timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exe_pipe_top.sv
`timescale 1ns/10ps
`include "exe_pipe_settings.svh"
`default_nettype none

module exe_pipe_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     in_valid_i,
    input  exe_pipe_pkg::alu_op_e    in_op_i,
    input  exe_pipe_pkg::reg_t       in_rd_i,
    input  exe_pipe_pkg::reg_t       in_rj_i,
    input  exe_pipe_pkg::reg_t       in_rk_i,
    input  logic [`EXE_IMM_BITS-1:0] in_imm_i,
    output logic                     ready_o,
    output logic                     wb_valid_o,
    output exe_pipe_pkg::reg_t       wb_rd_o,
    output exe_pipe_pkg::word_t      wb_data_o
);

    logic                  ex2_valid;
    exe_pipe_pkg::alu_op_e ex2_op;
    exe_pipe_pkg::reg_t    ex2_rd;
    exe_pipe_pkg::word_t   ex2_result;
    exe_pipe_pkg::word_t   ex2_mul_lo;
    exe_pipe_pkg::word_t   ex2_mul_mid;

    logic                  wb_valid;
    exe_pipe_pkg::reg_t    wb_rd;
    exe_pipe_pkg::word_t   wb_data;

    exe_pipe_pkg::reg_t    rf_rj;
    exe_pipe_pkg::reg_t    rf_rk;
    exe_pipe_pkg::word_t   rf_rj_data;
    exe_pipe_pkg::word_t   rf_rk_data;

    // producer slots for EX1 forwarding
    fwd_if fwd_ex2 ();
    fwd_if fwd_wb ();

    ex1_stage u_ex1 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_op_i       (in_op_i),
        .in_rd_i       (in_rd_i),
        .in_rj_i       (in_rj_i),
        .in_rk_i       (in_rk_i),
        .in_imm_i      (in_imm_i),
        .ready_o       (ready_o),
        .rf_rj_o       (rf_rj),
        .rf_rk_o       (rf_rk),
        .rf_rj_data_i  (rf_rj_data),
        .rf_rk_data_i  (rf_rk_data),
        .fwd_ex2       (fwd_ex2.sink),
        .fwd_wb        (fwd_wb.sink),
        .ex2_valid_o   (ex2_valid),
        .ex2_op_o      (ex2_op),
        .ex2_rd_o      (ex2_rd),
        .ex2_result_o  (ex2_result),
        .ex2_mul_lo_o  (ex2_mul_lo),
        .ex2_mul_mid_o (ex2_mul_mid)
    );

    ex2_stage u_ex2 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ex2_valid_i   (ex2_valid),
        .ex2_op_i      (ex2_op),
        .ex2_rd_i      (ex2_rd),
        .ex2_result_i  (ex2_result),
        .ex2_mul_lo_i  (ex2_mul_lo),
        .ex2_mul_mid_i (ex2_mul_mid),
        .fwd_ex2       (fwd_ex2.src),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    wb_stage u_wb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_valid_i   (wb_valid),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .rf_rj_i      (rf_rj),
        .rf_rk_i      (rf_rk),
        .rf_rj_data_o (rf_rj_data),
        .rf_rk_data_o (rf_rk_data),
        .fwd_wb       (fwd_wb.src),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
`timescale 1ns/10ps
`include "exe_pipe_settings.svh"
`default_nettype none

module wb_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                wb_valid_i,
    input  exe_pipe_pkg::reg_t  wb_rd_i,
    input  exe_pipe_pkg::word_t wb_data_i,
    input  exe_pipe_pkg::reg_t  rf_rj_i,
    input  exe_pipe_pkg::reg_t  rf_rk_i,
    output exe_pipe_pkg::word_t rf_rj_data_o,
    output exe_pipe_pkg::word_t rf_rk_data_o,
    fwd_if.src                  fwd_wb,
    output logic                wb_valid_o,
    output exe_pipe_pkg::reg_t  wb_rd_o,
    output exe_pipe_pkg::word_t wb_data_o
);

    localparam int NREG = 1 << `EXE_NREG_BITS;

    logic                wb_valid;
    exe_pipe_pkg::reg_t  wb_rd;
    exe_pipe_pkg::word_t wb_data;
    exe_pipe_pkg::word_t rf [NREG];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wb_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd   <= wb_rd_i;
        wb_data <= wb_data_i;
    end

    // architectural state starts at zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    assign rf_rj_data_o = (rf_rj_i == '0) ? '0 : rf[rf_rj_i];
    assign rf_rk_data_o = (rf_rk_i == '0) ? '0 : rf[rf_rk_i];

    assign fwd_wb.valid   = wb_valid && (wb_rd != '0);
    assign fwd_wb.rd      = wb_rd;
    assign fwd_wb.data_ok = 1'b1;
    assign fwd_wb.data    = wb_data;

    assign wb_valid_o = wb_valid;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

//--- verilog/ex2_stage.sv
`timescale 1ns/10ps
`include "exe_pipe_settings.svh"
`default_nettype none

module ex2_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  ex2_valid_i,
    input  exe_pipe_pkg::alu_op_e ex2_op_i,
    input  exe_pipe_pkg::reg_t    ex2_rd_i,
    input  exe_pipe_pkg::word_t   ex2_result_i,
    input  exe_pipe_pkg::word_t   ex2_mul_lo_i,
    input  exe_pipe_pkg::word_t   ex2_mul_mid_i,
    fwd_if.src                    fwd_ex2,
    output logic                  wb_valid_o,
    output exe_pipe_pkg::reg_t    wb_rd_o,
    output exe_pipe_pkg::word_t   wb_data_o
);

    localparam int HALF = `EXE_XLEN / 2;

    logic                  ex2_valid;
    exe_pipe_pkg::alu_op_e ex2_op;
    exe_pipe_pkg::reg_t    ex2_rd;
    exe_pipe_pkg::word_t   ex2_result;
    exe_pipe_pkg::word_t   ex2_mul_lo;
    exe_pipe_pkg::word_t   ex2_mul_mid;
    exe_pipe_pkg::word_t   ex2_data;
    logic                  is_mul;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex2_valid <= 1'b0;
        end else begin
            ex2_valid <= ex2_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ex2_op      <= ex2_op_i;
        ex2_rd      <= ex2_rd_i;
        ex2_result  <= ex2_result_i;
        ex2_mul_lo  <= ex2_mul_lo_i;
        ex2_mul_mid <= ex2_mul_mid_i;
    end

    assign is_mul = (ex2_op == exe_pipe_pkg::op_mul);

    // low 32 bits of the product
    assign ex2_data = is_mul ? ex2_mul_lo + (ex2_mul_mid << HALF) : ex2_result;

    // mul result only settles at the end of this stage
    assign fwd_ex2.valid   = ex2_valid && (ex2_rd != '0);
    assign fwd_ex2.rd      = ex2_rd;
    assign fwd_ex2.data_ok = ~is_mul;
    assign fwd_ex2.data    = ex2_data;

    assign wb_valid_o = ex2_valid;
    assign wb_rd_o    = ex2_rd;
    assign wb_data_o  = ex2_data;

endmodule

`default_nettype wire

//--- ex1/ex1_stage.sv
`timescale 1ns/10ps
`include "exe_pipe_settings.svh"
`default_nettype none

module ex1_stage (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       in_valid_i,
    input  exe_pipe_pkg::alu_op_e      in_op_i,
    input  exe_pipe_pkg::reg_t         in_rd_i,
    input  exe_pipe_pkg::reg_t         in_rj_i,
    input  exe_pipe_pkg::reg_t         in_rk_i,
    input  logic [`EXE_IMM_BITS-1:0]   in_imm_i,
    output logic                       ready_o,
    output exe_pipe_pkg::reg_t         rf_rj_o,
    output exe_pipe_pkg::reg_t         rf_rk_o,
    input  exe_pipe_pkg::word_t        rf_rj_data_i,
    input  exe_pipe_pkg::word_t        rf_rk_data_i,
    fwd_if.sink                        fwd_ex2,
    fwd_if.sink                        fwd_wb,
    output logic                       ex2_valid_o,
    output exe_pipe_pkg::alu_op_e      ex2_op_o,
    output exe_pipe_pkg::reg_t         ex2_rd_o,
    output exe_pipe_pkg::word_t        ex2_result_o,
    output exe_pipe_pkg::word_t        ex2_mul_lo_o,
    output exe_pipe_pkg::word_t        ex2_mul_mid_o
);

    localparam int HALF = `EXE_XLEN / 2;

    logic                     ex1_valid;
    exe_pipe_pkg::alu_op_e    ex1_op;
    exe_pipe_pkg::reg_t       ex1_rd;
    exe_pipe_pkg::reg_t       ex1_rj;
    exe_pipe_pkg::reg_t       ex1_rk;
    logic [`EXE_IMM_BITS-1:0] ex1_imm;

    exe_pipe_pkg::word_t op_a;
    exe_pipe_pkg::word_t op_b;
    logic                fwd_stall;
    logic                stall;

    // instruction register, held while stalled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex1_valid <= 1'b0;
        end else if (!stall) begin
            ex1_valid <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            ex1_op  <= in_op_i;
            ex1_rd  <= in_rd_i;
            ex1_rj  <= in_rj_i;
            ex1_rk  <= in_rk_i;
            ex1_imm <= in_imm_i;
        end
    end

    assign rf_rj_o = ex1_rj;
    assign rf_rk_o = ex1_rk;

    ex1_forward u_forward (
        .rj_i      (ex1_rj),
        .rk_i      (ex1_rk),
        .rj_data_i (rf_rj_data_i),
        .rk_data_i (rf_rk_data_i),
        .fwd_ex2   (fwd_ex2),
        .fwd_wb    (fwd_wb),
        .rj_data_o (op_a),
        .rk_data_o (op_b),
        .stall_o   (fwd_stall)
    );

    // a bubble in EX1 never waits on a producer
    assign stall   = ex1_valid & fwd_stall;
    assign ready_o = ~stall;

    always_comb begin
        case (ex1_op)
            exe_pipe_pkg::op_add: ex2_result_o = op_a + op_b;
            exe_pipe_pkg::op_sub: ex2_result_o = op_a - op_b;
            exe_pipe_pkg::op_and: ex2_result_o = op_a & op_b;
            exe_pipe_pkg::op_or:  ex2_result_o = op_a | op_b;
            exe_pipe_pkg::op_xor: ex2_result_o = op_a ^ op_b;
            exe_pipe_pkg::op_slt: begin
                ex2_result_o = {{(`EXE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            exe_pipe_pkg::op_li: begin
                ex2_result_o = {{(`EXE_XLEN-`EXE_IMM_BITS){ex1_imm[`EXE_IMM_BITS-1]}},
                                ex1_imm};
            end
            default: ex2_result_o = '0;
        endcase
    end

    // partial products, finished in EX2
    assign ex2_mul_lo_o  = op_a[HALF-1:0] * op_b[HALF-1:0];
    assign ex2_mul_mid_o = op_a[HALF-1:0] * op_b[`EXE_XLEN-1:HALF]
                         + op_a[`EXE_XLEN-1:HALF] * op_b[HALF-1:0];

    assign ex2_valid_o = ex1_valid & ~stall;
    assign ex2_op_o    = ex1_op;
    assign ex2_rd_o    = ex1_rd;

endmodule

`default_nettype wire

//--- ex1/ex1_forward.sv
`timescale 1ns/10ps
`default_nettype none

module ex1_forward (
    input  exe_pipe_pkg::reg_t  rj_i,
    input  exe_pipe_pkg::reg_t  rk_i,
    input  exe_pipe_pkg::word_t rj_data_i,
    input  exe_pipe_pkg::word_t rk_data_i,
    fwd_if.sink                 fwd_ex2,
    fwd_if.sink                 fwd_wb,
    output exe_pipe_pkg::word_t rj_data_o,
    output exe_pipe_pkg::word_t rk_data_o,
    output logic                stall_o
);

    logic stall_j;
    logic stall_k;

    // priority chain for one operand, younger slot first
    function automatic void resolve(
        input  exe_pipe_pkg::reg_t  src,
        input  exe_pipe_pkg::word_t rf_data,
        input  logic                ex2_valid,
        input  exe_pipe_pkg::reg_t  ex2_rd,
        input  logic                ex2_ok,
        input  exe_pipe_pkg::word_t ex2_data,
        input  logic                wb_valid,
        input  exe_pipe_pkg::reg_t  wb_rd,
        input  logic                wb_ok,
        input  exe_pipe_pkg::word_t wb_data,
        output exe_pipe_pkg::word_t data,
        output logic                stall
    );
        data  = rf_data;
        stall = 1'b0;
        // r0 always reads the register file zero
        if (src != '0) begin
            if (ex2_valid && ex2_rd == src) begin
                if (ex2_ok) begin
                    data = ex2_data;
                end else begin
                    stall = 1'b1;
                end
            end else if (wb_valid && wb_rd == src) begin
                if (wb_ok) begin
                    data = wb_data;
                end else begin
                    stall = 1'b1;
                end
            end
        end
    endfunction

    always_comb begin
        resolve(rj_i, rj_data_i,
                fwd_ex2.valid, fwd_ex2.rd, fwd_ex2.data_ok, fwd_ex2.data,
                fwd_wb.valid, fwd_wb.rd, fwd_wb.data_ok, fwd_wb.data,
                rj_data_o, stall_j);
        resolve(rk_i, rk_data_i,
                fwd_ex2.valid, fwd_ex2.rd, fwd_ex2.data_ok, fwd_ex2.data,
                fwd_wb.valid, fwd_wb.rd, fwd_wb.data_ok, fwd_wb.data,
                rk_data_o, stall_k);
    end

    assign stall_o = stall_j | stall_k;

endmodule

`default_nettype wire

//--- common/fwd_if.sv
`timescale 1ns/10ps
`default_nettype none

// one producer slot seen by the EX1 operand forwarding
interface fwd_if;
    logic                valid;
    exe_pipe_pkg::reg_t  rd;
    logic                data_ok;
    exe_pipe_pkg::word_t data;

    modport src (
        output valid, rd, data_ok, data
    );

    modport sink (
        input valid, rd, data_ok, data
    );
endinterface

`default_nettype wire

//--- common/exe_pipe_pkg.sv
`default_nettype none

package exe_pipe_pkg;

`include "exe_pipe_settings.svh"

    typedef logic [`EXE_XLEN-1:0] word_t;

    typedef logic [`EXE_NREG_BITS-1:0] reg_t;

    // mul stays last, the only two-cycle op
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_slt = 3'd5,
        op_li  = 3'd6,
        op_mul = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

//--- common/exe_pipe_settings.svh
`ifndef EXE_PIPE_SETTINGS_SVH
`define EXE_PIPE_SETTINGS_SVH

// datapath word width
`define EXE_XLEN 32

// register index width, 32 architectural registers
`define EXE_NREG_BITS 5

`define EXE_IMM_BITS 12

`endif
